// File: verilog.f
source/link_cfg_pkg.sv
source/link_types_pkg.sv
source/lane_serializer.sv
source/word_dispatcher.sv
source/word_collector.sv
source/serial_link_top.sv
bench/tb_clock_gen.sv
bench/tb_serial_link.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the serial link testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_serial_link
LOG_FILE=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    -f verilog.f --top-module tb_serial_link \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG_FILE"; then
    exit 0
else
    echo "Pass line not found in $LOG_FILE"
    exit 1
fi

// File: bench/tb_serial_link.sv
// Testbench for the serial word link loopback
// Host-side req/ack driver tasks, reference queue of sent words
// LCG stimulus, value check and five directed tests

`timescale 1ns/1ns
`default_nettype none

module tb_serial_link;

    localparam int TIMEOUT      = 1000;
    localparam int STALL_CYCLES = 100;
    localparam int BURST_WORDS  = 12;
    localparam int RAND_WORDS   = 50;

    logic                            clk;
    logic                            gen_rstn;
    logic                            run_rstn;
    logic                            dut_rstn;
    logic                            in_req;
    logic [link_cfg_pkg::WORD_W-1:0] in_word;
    logic                            in_ack;
    logic                            out_req;
    logic [link_cfg_pkg::WORD_W-1:0] out_word;
    logic                            out_ack;

    // Words accepted by the link, oldest first
    logic [link_cfg_pkg::WORD_W-1:0] sent_q [$];
    logic [31:0]                     lcg_state;

    // Pregenerated random traffic
    logic [link_cfg_pkg::WORD_W-1:0] rand_word    [RAND_WORDS];
    int                              rand_gap_in  [RAND_WORDS];
    int                              rand_gap_out [RAND_WORDS];

    tb_clock_gen i_clk_gen (
        .o_clk  (clk),
        .o_rstn (gen_rstn)
    );

    // Power-on reset combined with the mid-run reset of test 5
    assign dut_rstn = gen_rstn & run_rstn;

    serial_link_top i_dut (
        .i_clk      (clk),
        .i_rstn     (dut_rstn),
        .i_in_req   (in_req),
        .i_in_word  (in_word),
        .o_in_ack   (in_ack),
        .o_out_req  (out_req),
        .o_out_word (out_word),
        .i_out_ack  (out_ack)
    );

    ////////////////////////////////////////
    // Checking and stimulus helpers
    ////////////////////////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            report_failure($sformatf("CHECK FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                                     $time, name, got, expected));
        end
    endtask

    // Numerical Recipes constants
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Outputs sampled on the rising edge, before the DUT updates them
    task automatic wait_in_ack(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (in_ack !== level && cycles < TIMEOUT);
        if (in_ack !== level) begin
            report_failure($sformatf("Timeout: o_in_ack never went to %0b", level));
        end
    endtask

    task automatic wait_out_req(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (out_req !== level && cycles < TIMEOUT);
        if (out_req !== level) begin
            report_failure($sformatf("Timeout: o_out_req never went to %0b", level));
        end
    endtask

    // Raise req with the word held stable
    task automatic start_send(input logic [link_cfg_pkg::WORD_W-1:0] word);
        @(posedge clk);
        in_req  <= 1'b1;
        in_word <= word;
    endtask

    // Ack means the word sits in a lane, so it joins the reference queue
    task automatic finish_send(input logic [link_cfg_pkg::WORD_W-1:0] word);
        wait_in_ack(1'b1);
        sent_q.push_back(word);
        in_req <= 1'b0;
        wait_in_ack(1'b0);
    endtask

    task automatic send_word(input logic [link_cfg_pkg::WORD_W-1:0] word, input int gap);
        repeat (gap) @(posedge clk);
        start_send(word);
        finish_send(word);
    endtask

    // Output word must match the oldest word still outstanding
    task automatic recv_word(input int gap);
        logic [link_cfg_pkg::WORD_W-1:0] expected;
        wait_out_req(1'b1);
        if (sent_q.size() == 0) begin
            report_failure("Output req raised with no word outstanding");
        end
        expected = sent_q.pop_front();
        check_value("o_out_word", 32'(out_word), 32'(expected));
        repeat (gap) @(posedge clk);
        out_ack <= 1'b1;
        wait_out_req(1'b0);
        out_ack <= 1'b0;
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////

    // Idle outputs after reset, then one word round trip
    task automatic single_word_loopback();
        check_value("o_in_ack", 32'(in_ack), 32'd0);
        check_value("o_out_req", 32'(out_req), 32'd0);
        send_word(16'hA5C3, 0);
        recv_word(0);
    endtask

    task automatic burst_in_order();
        fork
            begin
                for (int i = 0; i < BURST_WORDS; i++) begin
                    send_word(16'(32'h1357 * (i + 1)), 0);
                end
            end
            begin
                repeat (BURST_WORDS) recv_word(0);
            end
        join
    endtask

    // Four lanes held full, the fifth word has nowhere to go
    task automatic back_pressure_stall();
        for (int i = 0; i < link_cfg_pkg::NUM_LANES; i++) begin
            send_word(16'(32'hB0B0 + i), 0);
        end
        // Pointed holding register is occupied
        wait_out_req(1'b1);
        start_send(16'hB5B5);
        for (int c = 0; c < STALL_CYCLES; c++) begin
            @(posedge clk);
            check_value("o_in_ack", 32'(in_ack), 32'd0);
        end
        // Releasing the host side drains all five in order
        fork
            finish_send(16'hB5B5);
            repeat (link_cfg_pkg::NUM_LANES + 1) recv_word(0);
        join
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        for (int i = 0; i < RAND_WORDS; i++) begin
            r = lcg_next();
            rand_word[i]   = r[31:16];
            rand_gap_in[i] = int'(r[15:13]);
            r = lcg_next();
            rand_gap_out[i] = int'(r[31:29]);
        end
        fork
            begin
                for (int i = 0; i < RAND_WORDS; i++) begin
                    send_word(rand_word[i], rand_gap_in[i]);
                end
            end
            begin
                for (int i = 0; i < RAND_WORDS; i++) begin
                    recv_word(rand_gap_out[i]);
                end
            end
        join
    endtask

    task automatic reset_during_burst();
        // One word back, one held in its register, a third acked with req still up
        send_word(16'hD100, 0);
        send_word(16'hD101, 0);
        recv_word(0);
        wait_out_req(1'b1);
        start_send(16'hDEAD);
        wait_in_ack(1'b1);
        // Both handshakes up, input pointer at lane 3 and output pointer at lane 1
        run_rstn <= 1'b0;
        repeat (4) @(posedge clk);
        check_value("o_in_ack", 32'(in_ack), 32'd0);
        check_value("o_out_req", 32'(out_req), 32'd0);
        run_rstn <= 1'b1;
        in_req   <= 1'b0;
        // Words in flight are gone
        sent_q.delete();
        // A lone word only returns if both pointers restarted at lane 0
        send_word(16'h0F0F, 1);
        recv_word(0);
        fork
            begin
                for (int i = 0; i < 5; i++) begin
                    send_word(16'(32'hE000 + i * 32'h0123), 0);
                end
            end
            begin
                repeat (5) recv_word(1);
            end
        join
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int cycles;
        in_req     = 1'b0;
        in_word    = '0;
        out_ack    = 1'b0;
        run_rstn   = 1'b1;
        lcg_state  = 32'h0f8a_90f2;
        cycles     = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!gen_rstn && cycles < TIMEOUT);
        if (!gen_rstn) begin
            report_failure("Reset was never released");
        end
        single_word_loopback();
        burst_in_order();
        back_pressure_stall();
        random_traffic();
        reset_during_burst();
        repeat (4) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
// Testbench clock and power-on reset
// 10 ns clock, active-low reset held for the first 4 rising edges

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rstn
);

    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 4;

    // Free-running clock
    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // Reset released on a rising edge, like every other stimulus
    initial begin
        o_rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rstn <= 1'b1;
    end

endmodule

`default_nettype wire

// File: source/serial_link_top.sv
// Top of the serial word link loopback
// Dispatcher, one serializer per lane and the collector

`timescale 1ns/1ns
`default_nettype none

module serial_link_top (
    input  logic                            i_clk,
    input  logic                            i_rstn,
    input  logic                            i_in_req,
    input  logic [link_cfg_pkg::WORD_W-1:0] i_in_word,
    output logic                            o_in_ack,
    output logic                            o_out_req,
    output logic [link_cfg_pkg::WORD_W-1:0] o_out_word,
    input  logic                            i_out_ack
);

    // Lane side wiring
    link_types_pkg::lane_load_t [link_cfg_pkg::NUM_LANES-1:0] lane_load;
    link_types_pkg::lane_ser_t  [link_cfg_pkg::NUM_LANES-1:0] lane_ser;
    logic [link_cfg_pkg::NUM_LANES-1:0]                       lane_busy;
    logic [link_cfg_pkg::NUM_LANES-1:0]                       lane_full;

    ////////////////////////////////////////
    // Input side
    ////////////////////////////////////////

    word_dispatcher u_dispatcher (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_in_req    (i_in_req),
        .i_in_word   (i_in_word),
        .o_in_ack    (o_in_ack),
        .i_lane_busy (lane_busy),
        .i_lane_full (lane_full),
        .o_load      (lane_load)
    );

    // One serializer per lane
    for (genvar i = 0; i < link_cfg_pkg::NUM_LANES; i++) begin : g_lane
        lane_serializer u_lane (
            .i_clk  (i_clk),
            .i_rstn (i_rstn),
            .i_load (lane_load[i]),
            .o_ser  (lane_ser[i]),
            .o_busy (lane_busy[i])
        );
    end

    ////////////////////////////////////////
    // Output side
    ////////////////////////////////////////

    // Serial bits looped straight back into the collector
    word_collector u_collector (
        .i_clk       (i_clk),
        .i_rstn      (i_rstn),
        .i_ser       (lane_ser),
        .o_lane_full (lane_full),
        .o_out_req   (o_out_req),
        .o_out_word  (o_out_word),
        .i_out_ack   (i_out_ack)
    );

endmodule

`default_nettype wire

// File: source/word_collector.sv
// Output side of the link
// Per-lane deserializers with holding registers and full flags
// In-order four-phase req/ack handshake back to the host

`timescale 1ns/1ns
`default_nettype none

module word_collector (
    input  logic                                                 i_clk,
    input  logic                                                 i_rstn,
    input  link_types_pkg::lane_ser_t [link_cfg_pkg::NUM_LANES-1:0] i_ser,
    output logic [link_cfg_pkg::NUM_LANES-1:0]                   o_lane_full,
    output logic                                                 o_out_req,
    output logic [link_cfg_pkg::WORD_W-1:0]                      o_out_word,
    input  logic                                                 i_out_ack
);

    // Output handshake states
    typedef enum logic [1:0] {
        OUT_IDLE = 2'd0,
        OUT_REQ  = 2'd1,
        OUT_DROP = 2'd2
    } out_state_t;

    // Per-lane deserializer state
    logic [link_cfg_pkg::WORD_W-2:0]    shift_q [link_cfg_pkg::NUM_LANES];
    logic [link_cfg_pkg::BIT_CNT_W-1:0] cnt_q   [link_cfg_pkg::NUM_LANES];
    logic [link_cfg_pkg::WORD_W-1:0]    hold_q  [link_cfg_pkg::NUM_LANES];
    logic [link_cfg_pkg::NUM_LANES-1:0] full_q;
    logic [link_cfg_pkg::NUM_LANES-1:0] full_clr;

    // Output side
    out_state_t                          state_q;
    logic [link_cfg_pkg::LANE_IDX_W-1:0] ptr_q;
    logic                                take;

    // Host ack empties the pointed holding register
    always_comb begin
        take              = (state_q == OUT_REQ) && i_out_ack;
        full_clr          = '0;
        full_clr[ptr_q]   = take;
    end

    ////////////////////////////////////////
    // Deserializers
    ////////////////////////////////////////

    // Bit count and full flags
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            cnt_q  <= '{default: '0};
            full_q <= '0;
        end else begin
            for (int i = 0; i < link_cfg_pkg::NUM_LANES; i++) begin
                if (i_ser[i].valid) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
                // Counter all ones marks the last bit of a word
                if (i_ser[i].valid && (&cnt_q[i])) begin
                    full_q[i] <= 1'b1;
                end else if (full_clr[i]) begin
                    full_q[i] <= 1'b0;
                end
            end
        end
    end

    // Shift in on valid, last bit goes straight into the holding register
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < link_cfg_pkg::NUM_LANES; i++) begin
            if (i_ser[i].valid) begin
                shift_q[i] <= {shift_q[i][link_cfg_pkg::WORD_W-3:0], i_ser[i].data};
                if (&cnt_q[i]) begin
                    hold_q[i] <= {shift_q[i], i_ser[i].data};
                end
            end
        end
    end

    ////////////////////////////////////////
    // Output handshake
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            state_q <= OUT_IDLE;
            ptr_q   <= '0;
        end else begin
            case (state_q)
                // Wait for the word of the pointed lane
                OUT_IDLE: begin
                    if (full_q[ptr_q]) begin
                        state_q <= OUT_REQ;
                    end
                end
                OUT_REQ: begin
                    if (i_out_ack) begin
                        state_q <= OUT_DROP;
                    end
                end
                // Next lane only once ack is low again
                OUT_DROP: begin
                    if (!i_out_ack) begin
                        ptr_q   <= ptr_q + 1'b1;
                        state_q <= OUT_IDLE;
                    end
                end
                default: state_q <= OUT_IDLE;
            endcase
        end
    end

    assign o_out_req   = (state_q == OUT_REQ);
    // Holding register stays put while req is up
    assign o_out_word  = hold_q[ptr_q];
    assign o_lane_full = full_q;

    // A full lane is never loaded again, so no bits can land on it
    for (genvar g = 0; g < link_cfg_pkg::NUM_LANES; g++) begin : g_chk
        a_no_valid_when_full: assert property (@(posedge i_clk) disable iff (!i_rstn)
            i_ser[g].valid |-> !full_q[g]);
    end

endmodule

`default_nettype wire

// File: source/word_dispatcher.sv
// Input side of the link
// Four-phase req/ack handshake with the host
// Round-robin loading of lanes that are neither busy nor full

`timescale 1ns/1ns
`default_nettype none

module word_dispatcher (
    input  logic                                                  i_clk,
    input  logic                                                  i_rstn,
    input  logic                                                  i_in_req,
    input  logic [link_cfg_pkg::WORD_W-1:0]                       i_in_word,
    output logic                                                  o_in_ack,
    input  logic [link_cfg_pkg::NUM_LANES-1:0]                    i_lane_busy,
    input  logic [link_cfg_pkg::NUM_LANES-1:0]                    i_lane_full,
    output link_types_pkg::lane_load_t [link_cfg_pkg::NUM_LANES-1:0] o_load
);

    // Handshake states
    typedef enum logic {
        IN_IDLE = 1'b0,
        IN_ACK  = 1'b1
    } in_state_t;

    in_state_t                           state_q;
    logic [link_cfg_pkg::LANE_IDX_W-1:0] ptr_q;
    logic [link_cfg_pkg::NUM_LANES-1:0]  strobe_q;
    logic [link_cfg_pkg::WORD_W-1:0]     word_q;
    logic                                accept;

    // Word taken when req is up and the pointed lane can take it
    always_comb begin
        accept = (state_q == IN_IDLE) && i_in_req &&
                 !i_lane_busy[ptr_q] && !i_lane_full[ptr_q];
    end

    ////////////////////////////////////////
    // Handshake and pointer
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            state_q  <= IN_IDLE;
            ptr_q    <= '0;
            strobe_q <= '0;
        end else begin
            // Load strobes last a single cycle
            strobe_q <= '0;
            case (state_q)
                IN_IDLE: begin
                    if (accept) begin
                        strobe_q[ptr_q] <= 1'b1;
                        ptr_q           <= ptr_q + 1'b1;
                        state_q         <= IN_ACK;
                    end
                end
                IN_ACK: begin
                    // Drop ack one cycle after req seen low
                    if (!i_in_req) begin
                        state_q <= IN_IDLE;
                    end
                end
                default: state_q <= IN_IDLE;
            endcase
        end
    end

    // Word held alongside the strobe
    always_ff @(posedge i_clk) begin
        if (accept) begin
            word_q <= i_in_word;
        end
    end

    // Ack rises together with the load strobe
    assign o_in_ack = (state_q == IN_ACK);

    // Same word on every lane, only the strobe picks the lane
    always_comb begin
        for (int i = 0; i < link_cfg_pkg::NUM_LANES; i++) begin
            o_load[i].load = strobe_q[i];
            o_load[i].data = word_q;
        end
    end

    // Host raises a new req only while ack is low
    a_req_rises_with_ack_low: assert property (@(posedge i_clk) disable iff (!i_rstn)
        $rose(i_in_req) |-> !o_in_ack);

endmodule

`default_nettype wire

// File: source/lane_serializer.sv
// Single serializer lane
// Two-state FSM, shift register and bit counter
// MSB-first serial output with valid strobe, busy flag for the dispatcher

`timescale 1ns/1ns
`default_nettype none

module lane_serializer (
    input  logic                       i_clk,
    input  logic                       i_rstn,
    input  link_types_pkg::lane_load_t i_load,
    output link_types_pkg::lane_ser_t  o_ser,
    output logic                       o_busy
);

    // Lane states
    typedef enum logic {
        LANE_IDLE = 1'b0,
        LANE_SEND = 1'b1
    } lane_state_t;

    lane_state_t                        state_q;
    lane_state_t                        state_d;
    logic [link_cfg_pkg::WORD_W-1:0]    shift_q;
    logic [link_cfg_pkg::BIT_CNT_W-1:0] cnt_q;
    logic                               valid_q;

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////

    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            state_q <= LANE_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Leave SEND once the counter reaches the last bit
    always_comb begin
        state_d = state_q;
        case (state_q)
            LANE_IDLE: begin
                if (i_load.load) begin
                    state_d = LANE_SEND;
                end
            end
            LANE_SEND: begin
                if (&cnt_q) begin
                    state_d = LANE_IDLE;
                end
            end
            default: state_d = LANE_IDLE;
        endcase
    end

    // Bit counter and valid strobe
    // First bit valid the cycle after load, 16 cycles in a row
    always_ff @(posedge i_clk) begin
        if (!i_rstn) begin
            cnt_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            case (state_q)
                LANE_IDLE: begin
                    cnt_q   <= '0;
                    valid_q <= i_load.load;
                end
                LANE_SEND: begin
                    // Wraps back to zero after the last bit
                    cnt_q   <= cnt_q + 1'b1;
                    valid_q <= ~&cnt_q;
                end
                default: begin
                    cnt_q   <= '0;
                    valid_q <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Data path
    ////////////////////////////////////////

    // Capture on load, shift left while sending
    always_ff @(posedge i_clk) begin
        if (state_q == LANE_IDLE && i_load.load) begin
            shift_q <= i_load.data;
        end else if (state_q == LANE_SEND) begin
            shift_q <= {shift_q[link_cfg_pkg::WORD_W-2:0], 1'b0};
        end
    end

    // MSB is the bit on the line
    assign o_ser.data  = shift_q[link_cfg_pkg::WORD_W-1];
    assign o_ser.valid = valid_q;
    assign o_busy      = (state_q == LANE_SEND);

    // Dispatcher must wait for the lane to drain
    a_no_load_when_busy: assert property (@(posedge i_clk) disable iff (!i_rstn)
        i_load.load |-> !o_busy);

endmodule

`default_nettype wire

// File: source/link_types_pkg.sv
// Bundles passed between dispatcher, lanes and collector
// Lane load request and lane serial output

`default_nettype none

package link_types_pkg;

    ////////////////////////////////////////
    // Dispatcher to lane
    ////////////////////////////////////////

    // One-cycle load strobe with the word to send
    // Data only meaningful while load is high
    typedef struct packed {
        logic                            load;
        logic [link_cfg_pkg::WORD_W-1:0] data;
    } lane_load_t;

    ////////////////////////////////////////
    // Lane to collector
    ////////////////////////////////////////

    // Serial bit, MSB of the word first
    // Valid high for every bit of a word, low between words
    typedef struct packed {
        logic data;
        logic valid;
    } lane_ser_t;

endpackage

`default_nettype wire

// File: source/link_cfg_pkg.sv
// Sizing constants for the serial word link
// Word width, lane count and the index and counter widths derived from them

`default_nettype none

package link_cfg_pkg;

    ////////////////////////////////////////
    // Base sizes
    ////////////////////////////////////////

    // Bits per host word
    localparam int WORD_W = 16;

    // Serializer lanes between dispatcher and collector
    localparam int NUM_LANES = 4;

    ////////////////////////////////////////
    // Derived widths
    ////////////////////////////////////////

    // Round-robin pointer width
    // Lane count is a power of two, so the pointer wraps by itself
    localparam int LANE_IDX_W = $clog2(NUM_LANES);

    // Bit position counter inside one word
    localparam int BIT_CNT_W = $clog2(WORD_W);

endpackage

`default_nettype wire
